/* include/snd_consts.svh */
`ifndef SND_CONSTS_SVH
`define SND_CONSTS_SVH

// APB register map, byte addresses
`define SND_ADDR_CTRL    4'h0
`define SND_ADDR_STATUS  4'h4

// Modulator enable ring length in clk_dac cycles
`define SND_CEN_PERIOD   4

// PCM sample width
`define SND_PCM_W        16

// Accumulator width, one carry bit above the sample
`define SND_ACC_W        (`SND_PCM_W + 1)

`endif

/* rtl/snd_pkg.sv */
`default_nettype none

package snd_pkg;

    // Control word fields, bit 0 is signed_snd
    typedef struct packed {
        logic [28:0] rsvd;
        logic        mute;
        logic        stereo;
        logic        signed_snd;
    } snd_ctrl_t;

    // Raw view for the bus side, field view for the sound path
    typedef union packed {
        logic [31:0] raw;
        snd_ctrl_t   f;
    } snd_ctrl_u;

endpackage

`default_nettype wire

/* rtl/snd_pcm_if.sv */
`default_nettype none
`include "snd_consts.svh"

interface snd_pcm_if;

    // Modulator clock enable, one clock in every ring period
    logic                  cen;
    // Conditioned samples, always offset binary
    logic [`SND_PCM_W-1:0] pcm_l;
    logic [`SND_PCM_W-1:0] pcm_r;
    // Right output copies the left channel
    logic                  mono;

    modport src (
        output cen,
        output pcm_l,
        output pcm_r,
        output mono
    );

    modport dac (
        input cen,
        input pcm_l,
        input pcm_r,
        input mono
    );

endinterface

`default_nettype wire

/* rtl/snd_apb_regs.sv */
`default_nettype none
`include "snd_consts.svh"

module snd_apb_regs
    import snd_pkg::*;
(
    input  wire                       clk_dac,
    input  wire                       rst,
    // APB slave
    input  wire                       psel_i,
    input  wire                       penable_i,
    input  wire                       pwrite_i,
    input  wire  [3:0]                paddr_i,
    input  wire  [31:0]               pwdata_i,
    output logic [31:0]               prdata_o,
    output logic                      pready_o,
    // Enable ring state for status readback
    input  wire  [`SND_CEN_PERIOD-1:0] ring_i,
    output snd_ctrl_u                 ctrl_o
);

    logic        wr_en;
    logic        rd_setup;
    logic [31:0] status_word;
    logic [31:0] rd_word;

    // No wait states
    assign pready_o = 1'b1;

    assign wr_en    = psel_i & penable_i & pwrite_i;
    assign rd_setup = psel_i & ~penable_i & ~pwrite_i;

    // Status: mute, effective stereo, ring state in bits 7:4
    assign status_word = {
        {(32 - 4 - `SND_CEN_PERIOD){1'b0}},
        ring_i,
        2'b00,
        ctrl_o.f.stereo,
        ctrl_o.f.mute
    };

    always_comb begin
        case (paddr_i)
            `SND_ADDR_CTRL:   rd_word = ctrl_o.raw;
            `SND_ADDR_STATUS: rd_word = status_word;
            default:          rd_word = 32'd0;
        endcase
    end

    // Control register, written at the end of the access phase
    always_ff @(posedge clk_dac or posedge rst) begin
        if (rst) begin
            ctrl_o.raw <= 32'd0;
        end else if (wr_en && paddr_i == `SND_ADDR_CTRL) begin
            ctrl_o.raw <= pwdata_i;
        end
    end

    // Read data captured in setup so it is stable through access
    always_ff @(posedge clk_dac or posedge rst) begin
        if (rst) begin
            prdata_o <= 32'd0;
        end else if (rd_setup) begin
            prdata_o <= rd_word;
        end
    end

endmodule

`default_nettype wire

/* rtl/snd_pcm_cond.sv */
`default_nettype none
`include "snd_consts.svh"

module snd_pcm_cond
    import snd_pkg::*;
(
    input  wire                        clk_dac,
    input  wire                        rst,
    input  snd_ctrl_u                  ctrl_i,
    input  wire  [`SND_PCM_W-1:0]      snd_left_i,
    input  wire  [`SND_PCM_W-1:0]      snd_right_i,
    output logic [`SND_CEN_PERIOD-1:0] ring_o,
    snd_pcm_if.src                     pcm
);

    // Two's complement to offset binary is a flip of the MSB
    function automatic logic [`SND_PCM_W-1:0] cond_sample(
        input logic [`SND_PCM_W-1:0] s,
        input logic                  is_signed,
        input logic                  mute
    );
        logic [`SND_PCM_W-1:0] ob;
        ob = {s[`SND_PCM_W-1] ^ is_signed, s[`SND_PCM_W-2:0]};
        return mute ? '0 : ob;
    endfunction

    // One-hot ring, first enable lands on the third clock after reset
    always_ff @(posedge clk_dac or posedge rst) begin
        if (rst) begin
            ring_o <= `SND_CEN_PERIOD'(4'b0100);
        end else begin
            ring_o <= {ring_o[`SND_CEN_PERIOD-2:0], ring_o[`SND_CEN_PERIOD-1]};
        end
    end

    assign pcm.cen  = ring_o[0];
    assign pcm.mono = ~ctrl_i.f.stereo;

    // Samples are level inputs, taken once per enable
    always_ff @(posedge clk_dac or posedge rst) begin
        if (rst) begin
            pcm.pcm_l <= '0;
            pcm.pcm_r <= '0;
        end else if (ring_o[0]) begin
            pcm.pcm_l <= cond_sample(snd_left_i, ctrl_i.f.signed_snd, ctrl_i.f.mute);
            pcm.pcm_r <= cond_sample(snd_right_i, ctrl_i.f.signed_snd, ctrl_i.f.mute);
        end
    end

endmodule

`default_nettype wire

/* rtl/sd_dac_1bit.sv */
`default_nettype none
`include "snd_consts.svh"

module sd_dac_1bit (
    input  wire   clk_dac,
    input  wire   rst,
    snd_pcm_if.dac pcm,
    // Tied per instance, picks which channel this modulator follows
    input  wire   sel_right_i,
    output logic  dac_o
);

    logic [`SND_PCM_W-1:0] code;
    logic [`SND_ACC_W-1:0] acc;
    logic [`SND_ACC_W-1:0] acc_next;

    assign code = sel_right_i ? pcm.pcm_r : pcm.pcm_l;

    // Carry out of the previous sum is dropped before adding
    assign acc_next = {1'b0, acc[`SND_PCM_W-1:0]} + {1'b0, code};

    always_ff @(posedge clk_dac or posedge rst) begin
        if (rst) begin
            acc <= '0;
        end else if (pcm.cen) begin
            acc <= acc_next;
        end
    end

    // Registered carry is the bitstream
    assign dac_o = acc[`SND_ACC_W-1];

endmodule

`default_nettype wire

/* rtl/snd_dac_base.sv */
`default_nettype none
`include "snd_consts.svh"

module snd_dac_base
    import snd_pkg::*;
(
    input  wire                   clk_dac,
    input  wire                   rst,
    // APB configuration port
    input  wire                   psel_i,
    input  wire                   penable_i,
    input  wire                   pwrite_i,
    input  wire  [3:0]            paddr_i,
    input  wire  [31:0]           pwdata_i,
    output logic [31:0]           prdata_o,
    output logic                  pready_o,
    // Sound
    input  wire  [`SND_PCM_W-1:0] snd_left_i,
    input  wire  [`SND_PCM_W-1:0] snd_right_i,
    output logic                  snd_pwm_left_o,
    output logic                  snd_pwm_right_o
);

    snd_ctrl_u                  ctrl;
    logic [`SND_CEN_PERIOD-1:0] ring;
    logic                       dac_left;
    logic                       dac_right;

    snd_pcm_if pcm_bus ();

    snd_apb_regs u_regs (
        .clk_dac   ( clk_dac   ),
        .rst       ( rst       ),
        .psel_i    ( psel_i    ),
        .penable_i ( penable_i ),
        .pwrite_i  ( pwrite_i  ),
        .paddr_i   ( paddr_i   ),
        .pwdata_i  ( pwdata_i  ),
        .prdata_o  ( prdata_o  ),
        .pready_o  ( pready_o  ),
        .ring_i    ( ring      ),
        .ctrl_o    ( ctrl      )
    );

    snd_pcm_cond u_cond (
        .clk_dac     ( clk_dac     ),
        .rst         ( rst         ),
        .ctrl_i      ( ctrl        ),
        .snd_left_i  ( snd_left_i  ),
        .snd_right_i ( snd_right_i ),
        .ring_o      ( ring        ),
        .pcm         ( pcm_bus.src )
    );

    sd_dac_1bit u_dac_left (
        .clk_dac     ( clk_dac     ),
        .rst         ( rst         ),
        .pcm         ( pcm_bus.dac ),
        .sel_right_i ( 1'b0        ),
        .dac_o       ( dac_left    )
    );

    sd_dac_1bit u_dac_right (
        .clk_dac     ( clk_dac     ),
        .rst         ( rst         ),
        .pcm         ( pcm_bus.dac ),
        .sel_right_i ( 1'b1        ),
        .dac_o       ( dac_right   )
    );

    assign snd_pwm_left_o  = dac_left;
    // In mono the right pin mirrors the left modulator
    assign snd_pwm_right_o = pcm_bus.mono ? dac_left : dac_right;

endmodule

`default_nettype wire

/* tests/snd_properties.sv */
`default_nettype none
`include "snd_consts.svh"

module snd_properties
    import snd_pkg::*;
(
    input  wire                        clk_dac,
    input  wire                        rst,
    input  snd_ctrl_u                  ctrl_i,
    input  wire  [`SND_CEN_PERIOD-1:0] ring_i,
    input  wire  [`SND_PCM_W-1:0]      pcm_l_i,
    input  wire  [`SND_PCM_W-1:0]      pcm_r_i
);

    int fail_cnt = 0;

    // Enable ring never loses or gains a token
    ring_onehot: assert property (@(posedge clk_dac) disable iff (rst) $onehot(ring_i))
        else begin
            $error("enable ring is not one-hot: %h", ring_i);
            fail_cnt++;
        end

    // A muted enable clears both samples
    mute_clears: assert property (@(posedge clk_dac) disable iff (rst)
        (ctrl_i.f.mute && ring_i[0]) |=> (pcm_l_i == '0 && pcm_r_i == '0))
        else begin
            $error("samples not cleared after muted enable");
            fail_cnt++;
        end

    // Cleared samples stay cleared while muted
    mute_holds: assert property (@(posedge clk_dac) disable iff (rst)
        (ctrl_i.f.mute && pcm_l_i == '0 && pcm_r_i == '0) |=> (pcm_l_i == '0 && pcm_r_i == '0))
        else begin
            $error("muted samples did not stay zero");
            fail_cnt++;
        end

endmodule

bind snd_pcm_cond snd_properties u_props (
    .clk_dac ( clk_dac   ),
    .rst     ( rst       ),
    .ctrl_i  ( ctrl_i    ),
    .ring_i  ( ring_o    ),
    .pcm_l_i ( pcm.pcm_l ),
    .pcm_r_i ( pcm.pcm_r )
);

`default_nettype wire

/* tests/snd_checker.sv */
`default_nettype none

module snd_checker (
    input  wire         clk_dac,
    input  wire         rst,
    input  wire         cen_i,
    input  wire         psel_i,
    input  wire         penable_i,
    input  wire         pwrite_i,
    input  wire  [3:0]  paddr_i,
    input  wire  [31:0] pwdata_i,
    input  wire  [31:0] prdata_i,
    input  wire         pready_i,
    input  wire  [15:0] left_i,
    input  wire  [15:0] right_i,
    input  wire         pwm_left_i,
    input  wire         pwm_right_i,
    input  wire         start_i,
    output logic        done_o,
    output int          checks_o,
    output int          errors_o
);

    localparam int WINDOW = 4096;

    logic [31:0] ctrl_model;
    logic [3:0]  ring_model;
    logic [3:0]  ring_setup;
    logic        written;
    logic        counting;
    int          n_cen;
    int          ones_l;
    int          ones_r;
    int          tol;

    // Ones expected over one window for a raw input sample
    function automatic int expected_ones(input logic [15:0] s);
        logic [15:0] code;
        code = s;
        // Two's complement shifted up by half scale
        if (ctrl_model[0]) code = s + 16'h8000;
        if (ctrl_model[2]) code = 16'h0000;
        return (int'(code) * WINDOW) / 65536;
    endfunction

    task automatic compare_count(input string name, input int exp, input int got,
                                 input int slack);
        checks_o++;
        if (got < exp - slack || got > exp + slack) begin
            errors_o++;
            $display("error %s exp %h got %h", name, exp, got);
        end
    endtask

    task automatic compare_word(input string name, input logic [31:0] exp,
                                input logic [31:0] got);
        checks_o++;
        if (got !== exp) begin
            errors_o++;
            $display("error %s exp %h got %h", name, exp, got);
        end
    endtask

    // Status shows the ring as it stood in the setup phase
    task automatic verify_read();
        logic [31:0] exp;
        exp = 32'h0;
        if (paddr_i == 4'h0) exp = ctrl_model;
        if (paddr_i == 4'h4) exp = {24'h0, ring_setup, 2'b00, ctrl_model[1], ctrl_model[2]};
        compare_word("prdata_o", exp, prdata_i);
    endtask

    always @(negedge clk_dac) begin
        if (rst) begin
            ctrl_model = 32'h0;
            ring_model = 4'b0010;
            ring_setup = 4'b0000;
            written    = 1'b0;
            counting   = 1'b0;
            done_o     = 1'b0;
            checks_o   = 0;
            errors_o   = 0;
        end else begin
            // Ring position in this cycle with the first enable on the third clock
            ring_setup = ring_model;
            ring_model = {ring_model[2:0], ring_model[3]};
            if (psel_i && penable_i && pready_i) begin
                if (!pwrite_i) begin
                    verify_read();
                end else if (paddr_i == 4'h0) begin
                    ctrl_model = pwdata_i;
                    written    = 1'b1;
                end
            end
            // Quiet outputs until the first control write
            if (!written) begin
                compare_count("snd_pwm_left_o", 0, int'(pwm_left_i), 0);
                compare_count("snd_pwm_right_o", 0, int'(pwm_right_i), 0);
            end
            if (counting) begin
                if (!ctrl_model[1]) begin
                    compare_count("snd_pwm_right_o", int'(pwm_left_i), int'(pwm_right_i), 0);
                end
                if (cen_i) begin
                    ones_l += int'(pwm_left_i);
                    ones_r += int'(pwm_right_i);
                    n_cen++;
                end
                if (n_cen == WINDOW) begin
                    tol = ctrl_model[2] ? 0 : 2;
                    compare_count("snd_pwm_left_o ones", expected_ones(left_i), ones_l, tol);
                    compare_count("snd_pwm_right_o ones",
                                  expected_ones(ctrl_model[1] ? right_i : left_i), ones_r, tol);
                    counting = 1'b0;
                    done_o   = 1'b1;
                end
            end else if (start_i && !done_o) begin
                counting = 1'b1;
                n_cen    = 0;
                ones_l   = 0;
                ones_r   = 0;
            end else if (!start_i) begin
                done_o = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* tests/snd_tb.sv */
`default_nettype none

module snd_tb;

    localparam int ROWS  = 14;
    localparam int LIMIT = 20000;

    logic        clk_dac = 1'b0;
    logic        rst;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [3:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic [15:0] snd_left;
    logic [15:0] snd_right;
    logic        pwm_l;
    logic        pwm_r;
    logic        start;
    logic        done;
    logic        aborted;
    int          chk_checks;
    int          chk_errors;
    int          timeouts;
    int          total;
    int          row;

    // Control word, left sample, right sample
    logic [63:0] row_tab [ROWS] = '{
        {32'h0000_0000, 16'h0000, 16'h0000},
        {32'h0000_0000, 16'hFFFF, 16'h1234},
        {32'h0000_0000, 16'h8000, 16'h0000},
        {32'h0000_0002, 16'h8000, 16'hFFFF},
        {32'h0000_0003, 16'h0000, 16'h7FFF},
        {32'h0000_0003, 16'h8000, 16'hFFFF},
        {32'h0000_0001, 16'hC000, 16'h0000},
        {32'h0000_0006, 16'hFFFF, 16'hFFFF},
        {32'hA5A5_0002, 16'h4000, 16'h2000},
        // Samples of the rows below come from $urandom
        {32'h0000_0000, 16'h0000, 16'h0000},
        {32'h0000_0002, 16'h0000, 16'h0000},
        {32'h0000_0003, 16'h0000, 16'h0000},
        {32'h0000_0005, 16'h0000, 16'h0000},
        {32'h0000_0001, 16'h0000, 16'h0000}
    };

    always #50 clk_dac = ~clk_dac;

    snd_dac_base uut (
        .clk_dac         ( clk_dac   ),
        .rst             ( rst       ),
        .psel_i          ( psel      ),
        .penable_i       ( penable   ),
        .pwrite_i        ( pwrite    ),
        .paddr_i         ( paddr     ),
        .pwdata_i        ( pwdata    ),
        .prdata_o        ( prdata    ),
        .pready_o        ( pready    ),
        .snd_left_i      ( snd_left  ),
        .snd_right_i     ( snd_right ),
        .snd_pwm_left_o  ( pwm_l     ),
        .snd_pwm_right_o ( pwm_r     )
    );

    snd_checker chk (
        .clk_dac     ( clk_dac     ),
        .rst         ( rst         ),
        .cen_i       ( uut.ring[0] ),
        .psel_i      ( psel        ),
        .penable_i   ( penable     ),
        .pwrite_i    ( pwrite      ),
        .paddr_i     ( paddr       ),
        .pwdata_i    ( pwdata      ),
        .prdata_i    ( prdata      ),
        .pready_i    ( pready      ),
        .left_i      ( snd_left    ),
        .right_i     ( snd_right   ),
        .pwm_left_i  ( pwm_l       ),
        .pwm_right_i ( pwm_r       ),
        .start_i     ( start       ),
        .done_o      ( done        ),
        .checks_o    ( chk_checks  ),
        .errors_o    ( chk_errors  )
    );

    task automatic next_drive();
        @(posedge clk_dac);
        #10;
    endtask

    // Setup phase, then access until pready
    task automatic apb_xfer(input logic wr, input logic [3:0] addr, input logic [31:0] data);
        int waited;
        waited = 0;
        next_drive();
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = data;
        next_drive();
        penable = 1'b1;
        @(negedge clk_dac);
        while (!pready && waited < LIMIT) begin
            @(negedge clk_dac);
            waited++;
        end
        if (!pready) begin
            $display("APB transfer to address %h never got pready", addr);
            timeouts++;
            aborted = 1'b1;
        end
        next_drive();
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic wait_enables(input int n);
        int seen;
        int waited;
        seen   = 0;
        waited = 0;
        while (seen < n && waited < LIMIT) begin
            @(negedge clk_dac);
            if (uut.ring[0]) seen++;
            waited++;
        end
        if (seen < n) begin
            $display("modulator enable stopped after %0d of %0d enables", seen, n);
            timeouts++;
            aborted = 1'b1;
        end
    endtask

    task automatic wait_done(input logic level);
        int waited;
        waited = 0;
        while (done !== level && waited < LIMIT) begin
            @(posedge clk_dac);
            waited++;
        end
        if (done !== level) begin
            $display("checker done flag never went to %0d", level);
            timeouts++;
            aborted = 1'b1;
        end
    endtask

    initial begin
        rst       = 1'b1;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = 4'h0;
        pwdata    = 32'h0;
        snd_left  = 16'h0;
        snd_right = 16'h0;
        start     = 1'b0;
        aborted   = 1'b0;
        timeouts  = 0;
        void'($urandom(32'haa6d_4157));
        for (int i = 9; i < ROWS; i++) begin
            row_tab[i][31:0] = $urandom();
        end
        repeat (10) @(posedge clk_dac);
        #10;
        rst = 1'b0;

        // Reset defaults and register map, before any control write
        wait_enables(4);
        apb_xfer(1'b0, 4'h0, 32'h0);
        apb_xfer(1'b0, 4'h4, 32'h0);
        apb_xfer(1'b0, 4'h8, 32'h0);
        apb_xfer(1'b1, 4'hC, 32'hDEAD_BEEF);
        apb_xfer(1'b0, 4'h0, 32'h0);

        row = 0;
        while (row < ROWS && !aborted) begin
            apb_xfer(1'b1, 4'h0, row_tab[row][63:32]);
            apb_xfer(1'b0, 4'h0, 32'h0);
            apb_xfer(1'b0, 4'h4, 32'h0);
            next_drive();
            snd_left  = row_tab[row][31:16];
            snd_right = row_tab[row][15:0];
            wait_enables(16);
            next_drive();
            start = 1'b1;
            wait_done(1'b1);
            next_drive();
            start = 1'b0;
            wait_done(1'b0);
            row++;
        end

        total = chk_errors + timeouts + uut.u_cond.u_props.fail_cnt;
        $display("checks %0d, errors %0d, timeouts %0d, assertion failures %0d",
                 chk_checks, chk_errors, timeouts, uut.u_cond.u_props.fail_cnt);
        if (total == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+include
rtl/snd_pkg.sv
rtl/snd_pcm_if.sv
rtl/snd_apb_regs.sv
rtl/snd_pcm_cond.sv
rtl/sd_dac_1bit.sv
rtl/snd_dac_base.sv
tests/snd_properties.sv
tests/snd_checker.sv
tests/snd_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the sound DAC testbench with Verilator
set -eo pipefail

cd "$(dirname "$0")"
LOG=sim.log

verilator --binary --timing -j 0 --top-module snd_tb -f filelist.f -o snd_sim

# Let assertion errors be counted instead of stopping at the first one
./obj_dir/snd_sim +verilator+error+limit+1000 | tee "$LOG"

if grep -q "CHECKS FAILED" "$LOG"; then
    echo "simulation failed, see $LOG"
    exit 1
fi
echo "simulation passed"
